// File: hdl/rv_pkg.sv
package rv_pkg;

    // ==================================================
    // default widths
    // ==================================================
    parameter int XLEN       = 32;  // data path width
    parameter int REG_ADDR_W = 5;   // x0..x31
    parameter int REG_DEPTH  = 32;  // number of gprs

    // ==================================================
    // major opcodes, instr[6:0]
    // ==================================================
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b000_0011,
        OPC_STORE  = 7'b010_0011,
        OPC_BRANCH = 7'b110_0011,
        OPC_JAL    = 7'b110_1111,
        OPC_JALR   = 7'b110_0111,
        OPC_OP_IMM = 7'b001_0011,
        OPC_OP     = 7'b011_0011,
        OPC_LUI    = 7'b011_0111,
        OPC_AUIPC  = 7'b001_0111
    } opcode_e;

    // alu operation handed to execute
    typedef enum logic [3:0] {
        ALU_ADD    = 4'h0,
        ALU_SUB    = 4'h1,  // also beq/bne compare
        ALU_SLL    = 4'h2,
        ALU_SRL    = 4'h3,
        ALU_SRA    = 4'h4,
        ALU_SLT    = 4'h5,  // blt/bge
        ALU_SLTU   = 4'h6,  // bltu/bgeu
        ALU_XOR    = 4'h7,
        ALU_OR     = 4'h8,
        ALU_AND    = 4'h9,
        ALU_PASS_B = 4'ha   // lui, operand b straight through
    } alu_op_e;

    // immediate layout selector for imm_gen
    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,  // r-type, no immediate
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_fmt_e;

    // ==================================================
    // bubble
    // ==================================================
    // addi x0, x0, 0
    parameter logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

// File: hdl/dec_ctrl_if.sv
`timescale 1ns/1ps

interface dec_ctrl_if #(
    parameter int ADDR_W = rv_pkg::REG_ADDR_W
);
    rv_pkg::alu_op_e    alu_op;
    rv_pkg::imm_fmt_e   imm_fmt;
    logic               use_imm;    // operand b from imm
    logic               reg_write;
    logic               mem_read;
    logic               mem_write;
    logic               branch;
    logic               jump;
    logic [ADDR_W-1:0]  rs1_addr;   // zero when unused
    logic [ADDR_W-1:0]  rs2_addr;
    logic [ADDR_W-1:0]  rd_addr;
    logic               illegal;

    modport decoder (output alu_op, imm_fmt, use_imm, reg_write, mem_read, mem_write,
                     branch, jump, rs1_addr, rs2_addr, rd_addr, illegal);

    // pipeline register only latches what execute needs
    modport sink (input alu_op, use_imm, reg_write, mem_read, mem_write,
                  branch, jump, rd_addr, illegal);

endinterface

// File: hdl/regfile.sv
`timescale 1ns/1ps

module regfile #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 5,
    parameter int DEPTH  = 32
) (
    input  logic              clk_i,
    input  logic              resetn_i,
    input  logic [ADDR_W-1:0] rs1_addr_i,
    input  logic [ADDR_W-1:0] rs2_addr_i,
    input  logic [ADDR_W-1:0] rd_addr_i,     // write-back target
    input  logic [DATA_W-1:0] rd_wr_data_i,
    input  logic              rd_wr_en_i,
    output logic [DATA_W-1:0] rs1_data_o,
    output logic [DATA_W-1:0] rs2_data_o
);

    logic [DATA_W-1:0] regs [DEPTH];
    logic              wr_commit;  // write will land at this edge

    assign wr_commit = rd_wr_en_i && (rd_addr_i != '0);

    // ==================================================
    // write port
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (!resetn_i) begin
            for (int i = 0; i < DEPTH; i++) begin  // every entry, last one too
                regs[i] <= '0;
            end
        end else if (wr_commit) begin
            regs[rd_addr_i] <= rd_wr_data_i;
        end
    end

    // read with same-cycle bypass from write-back
    function automatic logic [DATA_W-1:0] read_port(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] data;
        if (addr == '0) begin
            data = '0;                 // x0
        end else if (wr_commit && (addr == rd_addr_i)) begin
            data = rd_wr_data_i;       // forward
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    assign rs1_data_o = read_port(rs1_addr_i);
    assign rs2_data_o = read_port(rs2_addr_i);

    // x0 storage must never pick up a value
    a_x0_zero : assert property (@(posedge clk_i) disable iff (!resetn_i)
        regs[0] == '0)
        else $error("regfile: entry 0 nonzero");

endmodule

// File: hdl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [31:0]  instr_i,
    input  logic         instr_valid_i,
    dec_ctrl_if.decoder  ctrl
);

    rv_pkg::opcode_e opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            bad;                       // unsupported encoding
    logic            use_rs1, use_rs2, use_rd;  // fields present in format

    assign opcode = rv_pkg::opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // ==================================================
    // opcode / funct decode
    // ==================================================
    always_comb begin
        ctrl.alu_op    = rv_pkg::ALU_ADD;
        ctrl.imm_fmt   = rv_pkg::IMM_NONE;
        ctrl.use_imm   = 1'b0;
        ctrl.reg_write = 1'b0;
        ctrl.mem_read  = 1'b0;
        ctrl.mem_write = 1'b0;
        ctrl.branch    = 1'b0;
        ctrl.jump      = 1'b0;
        use_rs1        = 1'b0;
        use_rs2        = 1'b0;
        use_rd         = 1'b0;
        bad            = 1'b0;
        case (opcode)
            rv_pkg::OPC_LOAD: begin  // address = rs1 + imm
                ctrl.imm_fmt = rv_pkg::IMM_I;
                {ctrl.use_imm, ctrl.reg_write, ctrl.mem_read} = 3'b111;
                {use_rs1, use_rd} = 2'b11;
            end
            rv_pkg::OPC_STORE: begin
                ctrl.imm_fmt = rv_pkg::IMM_S;
                {ctrl.use_imm, ctrl.mem_write} = 2'b11;
                {use_rs1, use_rs2} = 2'b11;
            end
            rv_pkg::OPC_BRANCH: begin
                ctrl.imm_fmt = rv_pkg::IMM_B;
                ctrl.branch  = 1'b1;
                {use_rs1, use_rs2} = 2'b11;
                case (funct3[2:1])
                    2'b00:   ctrl.alu_op = rv_pkg::ALU_SUB;   // beq, bne
                    2'b10:   ctrl.alu_op = rv_pkg::ALU_SLT;   // blt, bge
                    2'b11:   ctrl.alu_op = rv_pkg::ALU_SLTU;  // bltu, bgeu
                    default: bad = 1'b1;                      // 010, 011 reserved
                endcase
            end
            rv_pkg::OPC_JAL: begin   // rd = pc + 4, target from imm
                ctrl.imm_fmt = rv_pkg::IMM_J;
                {ctrl.use_imm, ctrl.reg_write, ctrl.jump} = 3'b111;
                use_rd = 1'b1;
            end
            rv_pkg::OPC_JALR: begin
                ctrl.imm_fmt = rv_pkg::IMM_I;
                {ctrl.use_imm, ctrl.reg_write, ctrl.jump} = 3'b111;
                {use_rs1, use_rd} = 2'b11;
            end
            rv_pkg::OPC_OP_IMM: begin
                ctrl.imm_fmt = rv_pkg::IMM_I;
                {ctrl.use_imm, ctrl.reg_write} = 2'b11;
                {use_rs1, use_rd} = 2'b11;
                case (funct3)
                    3'b000: ctrl.alu_op = rv_pkg::ALU_ADD;
                    3'b010: ctrl.alu_op = rv_pkg::ALU_SLT;
                    3'b011: ctrl.alu_op = rv_pkg::ALU_SLTU;
                    3'b100: ctrl.alu_op = rv_pkg::ALU_XOR;
                    3'b110: ctrl.alu_op = rv_pkg::ALU_OR;
                    3'b111: ctrl.alu_op = rv_pkg::ALU_AND;
                    3'b001: begin                                  // slli
                        ctrl.alu_op = rv_pkg::ALU_SLL;
                        bad = (funct7 != 7'b000_0000);
                    end
                    default: begin                                 // srli / srai
                        ctrl.alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                        bad = ((funct7 & 7'b101_1111) != 7'b000_0000);
                    end
                endcase
            end
            rv_pkg::OPC_OP: begin
                ctrl.reg_write = 1'b1;
                {use_rs1, use_rs2, use_rd} = 3'b111;
                case (funct3)
                    3'b000:  ctrl.alu_op = funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b001:  ctrl.alu_op = rv_pkg::ALU_SLL;
                    3'b010:  ctrl.alu_op = rv_pkg::ALU_SLT;
                    3'b011:  ctrl.alu_op = rv_pkg::ALU_SLTU;
                    3'b100:  ctrl.alu_op = rv_pkg::ALU_XOR;
                    3'b101:  ctrl.alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'b110:  ctrl.alu_op = rv_pkg::ALU_OR;
                    default: ctrl.alu_op = rv_pkg::ALU_AND;
                endcase
                // only 0000000, or 0100000 on add/sub and srl/sra
                bad = ((funct7 & 7'b101_1111) != 7'b000_0000) ||
                      (funct7[5] && (funct3 != 3'b000) && (funct3 != 3'b101));
            end
            rv_pkg::OPC_LUI: begin   // rd = imm
                ctrl.alu_op  = rv_pkg::ALU_PASS_B;
                ctrl.imm_fmt = rv_pkg::IMM_U;
                {ctrl.use_imm, ctrl.reg_write} = 2'b11;
                use_rd = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin // rd = pc + imm
                ctrl.imm_fmt = rv_pkg::IMM_U;
                {ctrl.use_imm, ctrl.reg_write} = 2'b11;
                use_rd = 1'b1;
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin  // no architectural side effect from an illegal op
            {ctrl.reg_write, ctrl.mem_read, ctrl.mem_write} = 3'b000;
            {ctrl.branch, ctrl.jump} = 2'b00;
            use_rd = 1'b0;
        end
        ctrl.illegal  = bad && instr_valid_i;
        // no regfile read for an empty slot or an absent field
        ctrl.rs1_addr = (use_rs1 && instr_valid_i) ? instr_i[19:15] : '0;
        ctrl.rs2_addr = (use_rs2 && instr_valid_i) ? instr_i[24:20] : '0;
        ctrl.rd_addr  = use_rd ? instr_i[11:7] : '0;
    end

    always_comb begin
        a_mem_excl : assert (!(ctrl.mem_read && ctrl.mem_write))
            else $error("inst_decoder: load and store together");
    end

endmodule

// File: hdl/imm_gen.sv
`timescale 1ns/1ps

module imm_gen #(
    parameter int DATA_W = 32
) (
    input  logic [31:0]      instr_i,
    input  rv_pkg::imm_fmt_e imm_fmt_i,
    output logic [DATA_W-1:0] imm_o
);

    logic [31:0] imm32;  // 32-bit form before widening

    // ==================================================
    // per-format bit gather
    // ==================================================
    always_comb begin
        case (imm_fmt_i)
            rv_pkg::IMM_I: begin
                imm32 = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            rv_pkg::IMM_S: begin  // split around rd field
                imm32 = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            rv_pkg::IMM_B: begin  // bit 0 implied zero
                imm32 = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
            end
            rv_pkg::IMM_U: begin
                imm32 = {instr_i[31:12], 12'h000};
            end
            rv_pkg::IMM_J: begin  // +-1 MiB jump range
                imm32 = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            end
            default: begin
                imm32 = '0;       // r-type
            end
        endcase
    end

    // sign bit is always instr[31]
    assign imm_o = DATA_W'($signed(imm32));

endmodule

// File: hdl/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 5
) (
    input  logic              clk_i,
    input  logic              resetn_i,
    input  logic              stall_i,        // hold everything
    input  logic              flush_i,        // beats stall
    input  logic              instr_valid_i,
    dec_ctrl_if.sink          ctrl,
    input  logic [DATA_W-1:0] rs1_data_i,
    input  logic [DATA_W-1:0] rs2_data_i,
    input  logic [DATA_W-1:0] imm_i,
    output logic              ex_valid_o,
    output rv_pkg::alu_op_e   ex_alu_op_o,
    output logic              ex_use_imm_o,
    output logic              ex_reg_write_o,
    output logic              ex_mem_read_o,
    output logic              ex_mem_write_o,
    output logic              ex_branch_o,
    output logic              ex_jump_o,
    output logic              ex_illegal_o,
    output logic [ADDR_W-1:0] ex_rd_addr_o,
    output logic [DATA_W-1:0] ex_rs1_data_o,
    output logic [DATA_W-1:0] ex_rs2_data_o,
    output logic [DATA_W-1:0] ex_imm_o
);

    // bubble payload taken from the canonical nop
    localparam logic [ADDR_W-1:0] NOP_RD  = ADDR_W'(rv_pkg::NOP_INSTR[11:7]);
    localparam logic [DATA_W-1:0] NOP_IMM = DATA_W'($signed(rv_pkg::NOP_INSTR[31:20]));

    logic load_bubble;  // flush, or empty slot while not stalled
    logic load_instr;

    assign load_bubble = flush_i || (!stall_i && !instr_valid_i);
    assign load_instr  = !flush_i && !stall_i && instr_valid_i;

    // ==================================================
    // control levels
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (!resetn_i || load_bubble) begin
            ex_valid_o     <= 1'b0;
            ex_alu_op_o    <= rv_pkg::ALU_ADD;  // addi x0,x0,0
            ex_use_imm_o   <= 1'b1;
            ex_reg_write_o <= 1'b0;
            ex_mem_read_o  <= 1'b0;
            ex_mem_write_o <= 1'b0;
            ex_branch_o    <= 1'b0;
            ex_jump_o      <= 1'b0;
            ex_illegal_o   <= 1'b0;
        end else if (load_instr) begin
            ex_valid_o     <= 1'b1;
            ex_alu_op_o    <= ctrl.alu_op;
            ex_use_imm_o   <= ctrl.use_imm;
            ex_reg_write_o <= ctrl.reg_write;
            ex_mem_read_o  <= ctrl.mem_read;
            ex_mem_write_o <= ctrl.mem_write;
            ex_branch_o    <= ctrl.branch;
            ex_jump_o      <= ctrl.jump;
            ex_illegal_o   <= ctrl.illegal;
        end
    end

    // payload
    always_ff @(posedge clk_i) begin
        if (load_bubble) begin
            ex_rd_addr_o  <= NOP_RD;
            ex_rs1_data_o <= '0;
            ex_rs2_data_o <= '0;
            ex_imm_o      <= NOP_IMM;
        end else if (load_instr) begin
            ex_rd_addr_o  <= ctrl.rd_addr;
            ex_rs1_data_o <= rs1_data_i;
            ex_rs2_data_o <= rs2_data_i;
            ex_imm_o      <= imm_i;
        end
    end

    // a bubble must never retire a write
    a_wr_valid : assert property (@(posedge clk_i) disable iff (!resetn_i)
        ex_reg_write_o |-> ex_valid_o)
        else $error("id_ex_reg: reg_write on invalid slot");

endmodule

// File: hdl/id_stage.sv
`timescale 1ns/1ps

module id_stage #(
    parameter int DATA_W = rv_pkg::XLEN,
    parameter int ADDR_W = rv_pkg::REG_ADDR_W,
    parameter int DEPTH  = rv_pkg::REG_DEPTH
) (
    input  logic              clk_i,
    input  logic              resetn_i,
    // fetch
    input  logic [31:0]       instr_i,
    input  logic              instr_valid_i,
    // write-back
    input  logic              rd_wr_en_i,
    input  logic [ADDR_W-1:0] rd_addr_i,
    input  logic [DATA_W-1:0] rd_wr_data_i,
    // hazard control
    input  logic              stall_i,
    input  logic              flush_i,
    // to execute
    output logic              ex_valid_o,
    output rv_pkg::alu_op_e   ex_alu_op_o,
    output logic              ex_use_imm_o,
    output logic              ex_reg_write_o,
    output logic              ex_mem_read_o,
    output logic              ex_mem_write_o,
    output logic              ex_branch_o,
    output logic              ex_jump_o,
    output logic              ex_illegal_o,
    output logic [ADDR_W-1:0] ex_rd_addr_o,
    output logic [DATA_W-1:0] ex_rs1_data_o,
    output logic [DATA_W-1:0] ex_rs2_data_o,
    output logic [DATA_W-1:0] ex_imm_o
);

    logic [DATA_W-1:0] rs1_data;
    logic [DATA_W-1:0] rs2_data;
    logic [DATA_W-1:0] imm;

    dec_ctrl_if #(.ADDR_W(ADDR_W)) ctrl_if ();

    inst_decoder u_decoder (
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .ctrl          (ctrl_if)
    );

    imm_gen #(.DATA_W(DATA_W)) u_imm_gen (
        .instr_i   (instr_i),
        .imm_fmt_i (ctrl_if.imm_fmt),
        .imm_o     (imm)
    );

    regfile #(.DATA_W(DATA_W), .ADDR_W(ADDR_W), .DEPTH(DEPTH)) u_regfile (
        .clk_i        (clk_i),
        .resetn_i     (resetn_i),
        .rs1_addr_i   (ctrl_if.rs1_addr),  // zeroed by decoder when unused
        .rs2_addr_i   (ctrl_if.rs2_addr),
        .rd_addr_i    (rd_addr_i),
        .rd_wr_data_i (rd_wr_data_i),
        .rd_wr_en_i   (rd_wr_en_i),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data)
    );

    id_ex_reg #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) u_id_ex (
        .clk_i          (clk_i),
        .resetn_i       (resetn_i),
        .stall_i        (stall_i),
        .flush_i        (flush_i),
        .instr_valid_i  (instr_valid_i),
        .ctrl           (ctrl_if),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .imm_i          (imm),
        .ex_valid_o     (ex_valid_o),
        .ex_alu_op_o    (ex_alu_op_o),
        .ex_use_imm_o   (ex_use_imm_o),
        .ex_reg_write_o (ex_reg_write_o),
        .ex_mem_read_o  (ex_mem_read_o),
        .ex_mem_write_o (ex_mem_write_o),
        .ex_branch_o    (ex_branch_o),
        .ex_jump_o      (ex_jump_o),
        .ex_illegal_o   (ex_illegal_o),
        .ex_rd_addr_o   (ex_rd_addr_o),
        .ex_rs1_data_o  (ex_rs1_data_o),
        .ex_rs2_data_o  (ex_rs2_data_o),
        .ex_imm_o       (ex_imm_o)
    );

endmodule

// File: verification/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;

    localparam int MAX_CYCLES = 2000;  // tests need about 500 cycles

    // expected view of the id/ex register, msb first
    typedef struct packed {
        logic        valid;
        logic [3:0]  alu_op;
        logic        use_imm;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        branch;
        logic        jump;
        logic        illegal;
        logic [4:0]  rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
    } ex_t;

    logic            clk_i;
    logic            resetn_i;
    logic [31:0]     instr_i;
    logic            instr_valid_i;
    logic            rd_wr_en_i;
    logic [4:0]      rd_addr_i;
    logic [31:0]     rd_wr_data_i;
    logic            stall_i;
    logic            flush_i;
    logic            ex_valid_o;
    rv_pkg::alu_op_e ex_alu_op_o;
    logic            ex_use_imm_o;
    logic            ex_reg_write_o;
    logic            ex_mem_read_o;
    logic            ex_mem_write_o;
    logic            ex_branch_o;
    logic            ex_jump_o;
    logic            ex_illegal_o;
    logic [4:0]      ex_rd_addr_o;
    logic [31:0]     ex_rs1_data_o;
    logic [31:0]     ex_rs2_data_o;
    logic [31:0]     ex_imm_o;

    integer      seed;
    logic [31:0] model [32];   // expected gpr contents
    ex_t         exp_q[$];     // issued, not yet sampled by the DUT
    ex_t         armed_q[$];   // sampled at the last edge, due for compare
    ex_t         bubble;
    ex_t         last_exp;     // what a stall holds
    string       cur_test;
    int          checks;
    int          errors;
    int          chk0;
    int          err0;
    int          cycles;

    id_stage dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ==================================================
    // reference model
    // ==================================================
    function automatic logic [3:0] arith_op(input logic [2:0] f3, input logic alt);
        logic [3:0] op;
        case (f3)
            3'd0:    op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'd1:    op = rv_pkg::ALU_SLL;
            3'd2:    op = rv_pkg::ALU_SLT;
            3'd3:    op = rv_pkg::ALU_SLTU;
            3'd4:    op = rv_pkg::ALU_XOR;
            3'd5:    op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'd6:    op = rv_pkg::ALU_OR;
            default: op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    // rd1/rd2 report which source fields the format reads
    function automatic ex_t ref_decode(input logic [31:0] ins, output logic rd1,
                                       output logic rd2);
        ex_t        e;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       ill;
        logic       has_rd;
        e = '0;
        e.valid = 1'b1;
        f3 = ins[14:12];
        f7 = ins[31:25];
        {rd1, rd2, has_rd, ill} = 4'b0000;
        case (ins[6:0])
            7'h03: begin  // load
                {e.use_imm, e.reg_write, e.mem_read, rd1, has_rd} = 5'b11111;
                e.imm = {{20{ins[31]}}, ins[31:20]};
            end
            7'h23: begin  // store
                {e.use_imm, e.mem_write, rd1, rd2} = 4'b1111;
                e.imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            end
            7'h63: begin  // branch
                {e.branch, rd1, rd2} = 3'b111;
                e.imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                if (f3[2:1] == 2'b00) e.alu_op = rv_pkg::ALU_SUB;
                else if (f3[2:1] == 2'b10) e.alu_op = rv_pkg::ALU_SLT;
                else if (f3[2:1] == 2'b11) e.alu_op = rv_pkg::ALU_SLTU;
                else ill = 1'b1;
            end
            7'h6f: begin  // jal
                {e.use_imm, e.reg_write, e.jump, has_rd} = 4'b1111;
                e.imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'h67: begin  // jalr
                {e.use_imm, e.reg_write, e.jump, rd1, has_rd} = 5'b11111;
                e.imm = {{20{ins[31]}}, ins[31:20]};
            end
            7'h13: begin  // op-imm, shamt shares the imm field
                {e.use_imm, e.reg_write, rd1, has_rd} = 4'b1111;
                e.imm = {{20{ins[31]}}, ins[31:20]};
                e.alu_op = arith_op(f3, (f3 == 3'd5) && f7[5]);
                ill = ((f3 == 3'd1) && (f7 != 7'h00)) ||
                      ((f3 == 3'd5) && (f7 != 7'h00) && (f7 != 7'h20));
            end
            7'h33: begin  // register-register
                {e.reg_write, rd1, rd2, has_rd} = 4'b1111;
                e.alu_op = arith_op(f3, f7[5]);
                ill = !((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))));
            end
            7'h37: begin  // lui
                {e.use_imm, e.reg_write, has_rd} = 3'b111;
                e.alu_op = rv_pkg::ALU_PASS_B;
                e.imm = {ins[31:12], 12'h000};
            end
            7'h17: begin  // auipc
                {e.use_imm, e.reg_write, has_rd} = 3'b111;
                e.imm = {ins[31:12], 12'h000};
            end
            default: ill = 1'b1;
        endcase
        if (ill) begin
            {e.reg_write, e.mem_read, e.mem_write, e.branch, e.jump, has_rd} = 6'b0;
        end
        e.illegal = ill;
        e.rd = has_rd ? ins[11:7] : 5'd0;
        return e;
    endfunction

    // ==================================================
    // stimulus helpers
    // ==================================================
    function automatic logic [31:0] r_type(input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [4:0] rd);
        return {7'h00, rs2, rs1, 3'b000, rd, 7'h33};  // add rd, rs1, rs2
    endfunction

    // kind 0..8 picks a legal opcode, anything else an unsupported one
    function automatic logic [31:0] make_instr(input int kind);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] ins;
        r = $random(seed);
        f3 = r[14:12];
        case (kind)
            0: ins = {r[31:7], 7'h03};
            1: ins = {r[31:7], 7'h23};
            2: begin
                if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // skip reserved 010/011
                ins = {r[31:15], f3, r[11:7], 7'h63};
            end
            3: ins = {r[31:7], 7'h6f};
            4: ins = {r[31:15], 3'b000, r[11:7], 7'h67};
            5: begin
                if (f3 == 3'd1) f7 = 7'h00;
                else if (f3 == 3'd5) f7 = {1'b0, r[30], 5'b00000};
                else f7 = r[31:25];
                ins = {f7, r[24:15], f3, r[11:7], 7'h13};
            end
            6: begin
                f7 = (r[30] && ((f3 == 3'd0) || (f3 == 3'd5))) ? 7'h20 : 7'h00;
                ins = {f7, r[24:15], f3, r[11:7], 7'h33};
            end
            7: ins = {r[31:7], 7'h37};
            8: ins = {r[31:7], 7'h17};
            default: ins = {r[31:7], r[0] ? 7'h73 : (r[1] ? 7'h7f : 7'h0f)};
        endcase
        return ins;
    endfunction

    // one cycle of inputs plus the ex_* state expected after the next edge
    task automatic drive(input logic [31:0] ins, input logic vld, input logic stl,
                         input logic fls, input logic wen, input logic [4:0] wa,
                         input logic [31:0] wd);
        ex_t  e;
        logic r1;
        logic r2;
        @(posedge clk_i);
        instr_i       <= ins;
        instr_valid_i <= vld;
        stall_i       <= stl;
        flush_i       <= fls;
        rd_wr_en_i    <= wen;
        rd_addr_i     <= wa;
        rd_wr_data_i  <= wd;
        if (wen && (wa != 5'd0)) model[wa] = wd;  // visible to a read in the same cycle
        if (fls || (!stl && !vld)) begin
            e = bubble;
        end else if (stl) begin
            e = last_exp;
        end else begin
            e = ref_decode(ins, r1, r2);
            e.rs1 = r1 ? model[ins[19:15]] : 32'd0;  // unused field reads x0
            e.rs2 = r2 ? model[ins[24:20]] : 32'd0;
        end
        last_exp = e;
        exp_q.push_back(e);
    endtask

    task automatic issue(input logic [31:0] ins);
        drive(ins, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);
    endtask

    task automatic write_only(input logic [4:0] wa, input logic [31:0] wd);
        drive(rv_pkg::NOP_INSTR, 1'b0, 1'b0, 1'b0, 1'b1, wa, wd);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        chk0 = checks;
        err0 = errors;
    endtask

    task automatic end_test();
        while ((exp_q.size() != 0) || (armed_q.size() != 0)) @(negedge clk_i);
        $display("test %-12s %0d checks, %0d errors", cur_test, checks - chk0, errors - err0);
    endtask

    // ==================================================
    // comparator, between edges
    // ==================================================
    always @(negedge clk_i) begin : compare
        ex_t act;
        ex_t exp_v;
        act = {ex_valid_o, ex_alu_op_o, ex_use_imm_o, ex_reg_write_o, ex_mem_read_o,
               ex_mem_write_o, ex_branch_o, ex_jump_o, ex_illegal_o, ex_rd_addr_o,
               ex_rs1_data_o, ex_rs2_data_o, ex_imm_o};
        while (armed_q.size() != 0) begin
            exp_v = armed_q.pop_front();
            checks++;
            if (act !== exp_v) begin
                errors++;
                $display("mismatch %s: expected %h actual %h", cur_test, exp_v, act);
            end
        end
        while (exp_q.size() != 0) armed_q.push_back(exp_q.pop_front());
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ==================================================
    // test sequence
    // ==================================================
    initial begin : main
        logic        r1;
        logic        r2;
        logic [4:0]  wa;
        logic [31:0] wd;
        logic [31:0] a;
        seed = 32'h36b0;
        resetn_i      = 1'b0;
        instr_i       = rv_pkg::NOP_INSTR;
        instr_valid_i = 1'b0;
        rd_wr_en_i    = 1'b0;
        rd_addr_i     = 5'd0;
        rd_wr_data_i  = 32'd0;
        stall_i       = 1'b0;
        flush_i       = 1'b0;
        checks = 0;
        errors = 0;
        for (int k = 0; k < 32; k++) model[k] = 32'd0;
        bubble = ref_decode(rv_pkg::NOP_INSTR, r1, r2);  // nop payload, no valid, no side effect
        bubble.valid = 1'b0;
        {bubble.reg_write, bubble.mem_read, bubble.mem_write} = 3'b000;
        {bubble.branch, bubble.jump} = 2'b00;
        last_exp = bubble;
        repeat (5) @(posedge clk_i);
        resetn_i <= 1'b1;

        begin_test("reset_state");
        @(negedge clk_i);
        checks++;
        if ({ex_valid_o, ex_reg_write_o, ex_mem_read_o, ex_mem_write_o,
             ex_branch_o, ex_jump_o} !== 6'b000000) begin
            errors++;
            $display("reset_state: valid or a side-effect output is not low after reset");
        end
        for (int k = 1; k < 32; k++) issue(r_type(5'(k), 5'(32 - k), 5'(k)));
        end_test();

        begin_test("write_read");
        repeat (50) begin
            wa = 5'(($unsigned($random(seed)) % 31) + 1);  // x1..x31
            wd = $random(seed);
            write_only(wa, wd);
        end
        for (int k = 1; k < 32; k++) issue(r_type(5'(k), 5'((k * 7) % 32), 5'd1));
        end_test();

        begin_test("x0_hardwired");
        repeat (5) write_only(5'd0, $random(seed));
        drive(r_type(5'd0, 5'd0, 5'd3), 1'b1, 1'b0, 1'b0, 1'b1, 5'd0, 32'hdead_beef);
        issue(r_type(5'd0, 5'd0, 5'd4));
        end_test();

        begin_test("bypass");
        repeat (20) begin
            wa = 5'(($unsigned($random(seed)) % 31) + 1);
            wd = $random(seed);
            drive(r_type(wa, wa, 5'd2), 1'b1, 1'b0, 1'b0, 1'b1, wa, wd);
        end
        end_test();

        begin_test("decode_imm");
        for (int k = 0; k < 300; k++) issue(make_instr(k % 9));
        repeat (20) issue(make_instr(9));  // unsupported opcodes
        end_test();

        begin_test("stall_flush");
        a = make_instr(5);
        issue(a);
        drive(make_instr(6), 1'b1, 1'b1, 1'b0, 1'b0, 5'd0, 32'd0);
        drive(make_instr(0), 1'b1, 1'b1, 1'b0, 1'b1, a[19:15], 32'h1234_5678);  // held data stays old
        drive(make_instr(3), 1'b1, 1'b1, 1'b0, 1'b0, 5'd0, 32'd0);
        drive(make_instr(0), 1'b1, 1'b0, 1'b1, 1'b0, 5'd0, 32'd0);  // flush
        issue(a);
        drive(make_instr(1), 1'b1, 1'b1, 1'b1, 1'b0, 5'd0, 32'd0);  // flush beats stall
        issue(a);
        drive(a, 1'b0, 1'b1, 1'b0, 1'b0, 5'd0, 32'd0);  // stalled empty slot keeps a
        drive(a, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // empty slot
        issue(make_instr(7));
        end_test();

        $display("total %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: compile.f
hdl/rv_pkg.sv
hdl/dec_ctrl_if.sv
hdl/regfile.sv
hdl/inst_decoder.sv
hdl/imm_gen.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
verification/tb_id_stage.sv

// File: Makefile
# Verilator build and run for the ID stage testbench

VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard hdl/*.sv verification/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** TEST PASSED ***' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
